// ==== src/bp_params.svh ====
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// Bank organisation
`define BP_BANKS    4
`define BP_BANK_W   2

// Table geometry, 64 sets per bank
`define BP_INDEX_W  6
`define BP_CTR_W    2
`define BP_CTRS     4

`define BP_HIST_W   6
`define BP_PC_W     32

`endif

// ==== src/bp_pkg.sv ====
`include "bp_params.svh"

package bp_pkg;

    typedef logic [`BP_PC_W-1:0]          pc_t;
    typedef logic [`BP_HIST_W-1:0]        ghr_t;        // Newest outcome in bit 0
    typedef logic [`BP_BANK_W-1:0]        bank_id_t;
    typedef logic [`BP_INDEX_W-1:0]       set_index_t;
    typedef logic [$clog2(`BP_CTRS)-1:0]  ctr_sel_t;
    typedef logic [`BP_CTR_W-1:0]         ctr_t;
    typedef ctr_t [`BP_CTRS-1:0]          set_ctrs_t;   // Counter 0 in the low bits
    typedef logic [31:0]                  miss_count_t;

    ////////////////////////////////////////
    // Per-bank access structs

    typedef struct packed {
        logic       en;
        set_index_t index;
        ctr_sel_t   sel;
    } bht_lookup_t;

    typedef struct packed {
        logic       en;
        set_index_t index;
        ctr_sel_t   sel;
        logic       taken;      // Taken counts up, not taken counts down
    } bht_update_t;

    typedef struct packed {
        set_ctrs_t  data;
        logic       valid;
    } bht_read_t;

endpackage

// ==== src/bp_index_hash.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_index_hash (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                lookup_valid,
    input  logic                update_valid,
    input  logic                update_taken,
    input  bp_pkg::pc_t         lookup_pc,
    input  bp_pkg::pc_t         update_pc,
    input  bp_pkg::ghr_t        update_history,
    output bp_pkg::bht_lookup_t bank_lookup [`BP_BANKS],
    output bp_pkg::bht_update_t bank_update [`BP_BANKS],
    output bp_pkg::bank_id_t    lookup_bank,
    output bp_pkg::ctr_sel_t    lookup_sel,
    output bp_pkg::ghr_t        lookup_history
);
    import bp_pkg::*;

    localparam int SEL_LSB = 2 + `BP_BANK_W;
    localparam int IDX_LSB = SEL_LSB + $bits(ctr_sel_t);

    ghr_t       ghr_q;
    bank_id_t   update_bank;
    ctr_sel_t   update_sel;
    set_index_t lookup_index;
    set_index_t update_index;

    // gshare set index, PC index bits folded with history
    function automatic set_index_t hash_index(pc_t pc, ghr_t hist);
        return pc[IDX_LSB +: `BP_INDEX_W] ^ set_index_t'(hist);
    endfunction

    assign lookup_bank    = lookup_pc[2 +: `BP_BANK_W];
    assign lookup_sel     = lookup_pc[SEL_LSB +: $bits(ctr_sel_t)];
    assign lookup_index   = hash_index(lookup_pc, ghr_q);  // Pre-shift history
    assign lookup_history = ghr_q;

    assign update_bank    = update_pc[2 +: `BP_BANK_W];
    assign update_sel     = update_pc[SEL_LSB +: $bits(ctr_sel_t)];
    assign update_index   = hash_index(update_pc, update_history);

    // Steer each request to its bank only
    always_comb begin
        for (int b = 0; b < `BP_BANKS; b++) begin
            bank_lookup[b].en    = lookup_valid && (lookup_bank == bank_id_t'(b));
            bank_lookup[b].index = lookup_index;
            bank_lookup[b].sel   = lookup_sel;
            bank_update[b].en    = update_valid && (update_bank == bank_id_t'(b));
            bank_update[b].index = update_index;
            bank_update[b].sel   = update_sel;
            bank_update[b].taken = update_taken;
        end
    end

    ////////////////////////////////////////
    // Global history register

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ghr_q <= '0;
        end else if (update_valid) begin
            ghr_q <= {ghr_q[`BP_HIST_W-2:0], update_taken};  // Newest into bit 0
        end
    end

endmodule

// ==== src/bht_bank.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module bht_bank (
    input  logic                clock,
    input  logic                reset_n,
    input  bp_pkg::bht_lookup_t lookup,
    input  bp_pkg::bht_update_t update,
    output bp_pkg::bht_read_t   read,
    output bp_pkg::miss_count_t miss_count
);
    import bp_pkg::*;

    localparam int SETS = 1 << `BP_INDEX_W;

    set_ctrs_t        ctrs_q [SETS];     // Four counters per set
    logic [SETS-1:0]  valid_q;           // One valid bit per set

    set_ctrs_t        upd_set;           // Set contents after the update
    set_ctrs_t        rd_set;
    logic             rd_valid;
    logic             same_set;

    // Two-bit saturating step toward the outcome
    function automatic ctr_t ctr_step(ctr_t c, logic taken);
        if (taken) begin
            return (c == '1) ? c : c + 1'b1;
        end else begin
            return (c == '0) ? c : c - 1'b1;
        end
    endfunction

    ////////////////////////////////////////
    // Update path

    always_comb begin
        upd_set = ctrs_q[update.index];
        upd_set[update.sel] = ctr_step(ctrs_q[update.index][update.sel], update.taken);
    end

    ////////////////////////////////////////
    // Read path with write bypass

    assign same_set = update.en && (update.index == lookup.index);
    assign rd_set   = same_set ? upd_set : ctrs_q[lookup.index];
    assign rd_valid = same_set || valid_q[lookup.index];  // Update marks set valid

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < SETS; s++) begin
                ctrs_q[s] <= '0;
            end
            valid_q <= '0;
        end else if (update.en) begin
            ctrs_q[update.index]  <= upd_set;
            valid_q[update.index] <= 1'b1;
        end
    end

    // Registered read, held while no lookup arrives
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read <= '0;
        end else if (lookup.en) begin
            read.data  <= rd_set;
            read.valid <= rd_valid;
        end
    end

    ////////////////////////////////////////
    // Miss counter

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            miss_count <= '0;
        end else if (lookup.en && !rd_valid) begin
            miss_count <= miss_count + 1'b1;  // Lookup found the set invalid
        end
    end

endmodule

// ==== src/bp_predict_select.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_predict_select (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                lookup_valid,
    input  bp_pkg::bank_id_t    lookup_bank,
    input  bp_pkg::ctr_sel_t    lookup_sel,
    input  bp_pkg::ghr_t        lookup_history,
    input  bp_pkg::bht_read_t   bank_read [`BP_BANKS],
    input  bp_pkg::miss_count_t bank_miss [`BP_BANKS],
    output logic                pred_valid,
    output logic                pred_taken,
    output logic                pred_hit,
    output bp_pkg::ctr_t        pred_counter,
    output bp_pkg::ghr_t        pred_history,
    output bp_pkg::miss_count_t miss_count
);
    import bp_pkg::*;

    logic       valid_q;
    bank_id_t   bank_q;
    ctr_sel_t   sel_q;
    ghr_t       hist_q;
    bht_read_t  sel_read;

    // Stage aligned with the one-cycle bank read
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
            bank_q  <= '0;
            sel_q   <= '0;
            hist_q  <= '0;
        end else begin
            valid_q <= lookup_valid;
            if (lookup_valid) begin
                bank_q <= lookup_bank;
                sel_q  <= lookup_sel;
                hist_q <= lookup_history;
            end
        end
    end

    assign sel_read     = bank_read[bank_q];
    assign pred_valid   = valid_q;
    assign pred_counter = sel_read.data[sel_q];
    assign pred_taken   = pred_counter[`BP_CTR_W-1];   // Upper bit gives direction
    assign pred_hit     = sel_read.valid;
    assign pred_history = hist_q;

    // Total misses over all banks
    always_comb begin
        miss_count = '0;
        for (int b = 0; b < `BP_BANKS; b++) begin
            miss_count = miss_count + bank_miss[b];
        end
    end

endmodule

// ==== src/bp_top.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_top (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                lookup_valid,
    input  bp_pkg::pc_t         lookup_pc,
    input  logic                update_valid,
    input  bp_pkg::pc_t         update_pc,
    input  logic                update_taken,
    input  bp_pkg::ghr_t        update_history,
    output logic                pred_valid,
    output logic                pred_taken,
    output logic                pred_hit,
    output bp_pkg::ctr_t        pred_counter,
    output bp_pkg::ghr_t        pred_history,
    output bp_pkg::miss_count_t miss_count
);
    import bp_pkg::*;

    bht_lookup_t bank_lookup [`BP_BANKS];
    bht_update_t bank_update [`BP_BANKS];
    bht_read_t   bank_read   [`BP_BANKS];
    miss_count_t bank_miss   [`BP_BANKS];
    bank_id_t    lookup_bank;
    ctr_sel_t    lookup_sel;
    ghr_t        lookup_history;

    ////////////////////////////////////////
    // Front end, banks, select

    bp_index_hash u_hash (
        .clock          (clock),
        .reset_n        (reset_n),
        .lookup_valid   (lookup_valid),
        .update_valid   (update_valid),
        .update_taken   (update_taken),
        .lookup_pc      (lookup_pc),
        .update_pc      (update_pc),
        .update_history (update_history),
        .bank_lookup    (bank_lookup),
        .bank_update    (bank_update),
        .lookup_bank    (lookup_bank),
        .lookup_sel     (lookup_sel),
        .lookup_history (lookup_history)
    );

    for (genvar b = 0; b < `BP_BANKS; b++) begin : g_bank
        bht_bank u_bank (
            .clock      (clock),
            .reset_n    (reset_n),
            .lookup     (bank_lookup[b]),
            .update     (bank_update[b]),
            .read       (bank_read[b]),
            .miss_count (bank_miss[b])
        );
    end

    bp_predict_select u_select (
        .clock          (clock),
        .reset_n        (reset_n),
        .lookup_valid   (lookup_valid),
        .lookup_bank    (lookup_bank),
        .lookup_sel     (lookup_sel),
        .lookup_history (lookup_history),
        .bank_read      (bank_read),
        .bank_miss      (bank_miss),
        .pred_valid     (pred_valid),
        .pred_taken     (pred_taken),
        .pred_hit       (pred_hit),
        .pred_counter   (pred_counter),
        .pred_history   (pred_history),
        .miss_count     (miss_count)
    );

endmodule

// ==== dv/bp_tb.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_tb;
    import bp_pkg::*;

    localparam int SETS        = 1 << `BP_INDEX_W;
    localparam int IDX_LSB     = 4 + `BP_BANK_W;        // Index bits sit above bank and select
    localparam int MAX_CYCLES  = 2000;
    localparam int RAND_CYCLES = 400;
    localparam int POOL_N      = 12;
    localparam pc_t PC_A = 32'h0000_0150;               // Bank 0, counter 1
    localparam pc_t PC_B = 32'h0000_02a4;               // Bank 1, counter 2
    localparam pc_t PC_C = 32'h0000_0c38;               // Bank 2, counter 3

    logic        clock = 1'b0;
    logic        reset_n;
    logic        lookup_valid;
    pc_t         lookup_pc;
    logic        update_valid;
    pc_t         update_pc;
    logic        update_taken;
    ghr_t        update_history;
    logic        pred_valid;
    logic        pred_taken;
    logic        pred_hit;
    ctr_t        pred_counter;
    ghr_t        pred_history;
    miss_count_t miss_count;

    // Reference model state
    ctr_t        model_ctr [`BP_BANKS][SETS][`BP_CTRS];
    logic        model_valid [`BP_BANKS][SETS];
    ghr_t        model_ghr;
    miss_count_t model_miss;

    // One-deep slot for the lookup in flight
    logic        exp_valid;
    ctr_t        exp_ctr;
    logic        exp_hit;
    logic        exp_taken;
    ghr_t        exp_hist;

    int          mismatch_count;
    int          other_errors;
    int          cycle_count;
    logic [31:0] rng;
    pc_t         pool [POOL_N];

    bp_top u_dut (
        .clock          (clock),
        .reset_n        (reset_n),
        .lookup_valid   (lookup_valid),
        .lookup_pc      (lookup_pc),
        .update_valid   (update_valid),
        .update_pc      (update_pc),
        .update_taken   (update_taken),
        .update_history (update_history),
        .pred_valid     (pred_valid),
        .pred_taken     (pred_taken),
        .pred_hit       (pred_hit),
        .pred_counter   (pred_counter),
        .pred_history   (pred_history),
        .miss_count     (miss_count)
    );

    always #4 clock = ~clock;

    ////////////////////////////////////////
    // PC rule and counter rule

    function automatic int pc_bank(pc_t pc);
        return int'(pc[2 +: `BP_BANK_W]);
    endfunction

    function automatic int pc_sel(pc_t pc);
        return int'(pc[2 + `BP_BANK_W +: 2]);
    endfunction

    function automatic int pc_set(pc_t pc, ghr_t hist);
        return int'(pc[IDX_LSB +: `BP_INDEX_W] ^ hist);
    endfunction

    function automatic ctr_t sat_step(ctr_t c, logic taken);
        if (taken && c != 2'd3) begin
            return c + 2'd1;
        end else if (!taken && c != 2'd0) begin
            return c - 2'd1;
        end
        return c;
    endfunction

    // PC whose lookup under the live history lands on the set that hist selected
    function automatic pc_t retarget_pc(pc_t pc, ghr_t hist);
        pc_t p;
        p = pc;
        p[IDX_LSB +: `BP_INDEX_W] = pc[IDX_LSB +: `BP_INDEX_W] ^ hist ^ model_ghr;
        return p;
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////////////////////////
    // Model and checks

    task automatic apply_model(input logic lv, input pc_t lpc, input logic uv,
                               input pc_t upc, input logic ut, input ghr_t uh);
        int b;
        int s;
        int c;
        if (uv) begin                                   // Update first gives the bypass
            b = pc_bank(upc);
            s = pc_set(upc, uh);
            c = pc_sel(upc);
            model_ctr[b][s][c] = sat_step(model_ctr[b][s][c], ut);
            model_valid[b][s] = 1'b1;
        end
        exp_valid = lv;
        if (lv) begin
            b = pc_bank(lpc);
            s = pc_set(lpc, model_ghr);
            c = pc_sel(lpc);
            exp_ctr   = model_ctr[b][s][c];
            exp_hit   = model_valid[b][s];
            exp_taken = exp_ctr[1];
            exp_hist  = model_ghr;
            if (!exp_hit) begin
                model_miss = model_miss + 32'd1;
            end
        end
        if (uv) begin
            model_ghr = {model_ghr[`BP_HIST_W-2:0], ut};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        mismatch_count++;
        $display("MISMATCH %s expected 0x%h actual 0x%h at %0t", name, exp_val, act_val, $time);
    endtask

    task automatic check_outputs();
        assert (pred_valid === exp_valid)
            else report_mismatch("pred_valid", 32'(exp_valid), 32'(pred_valid));
        if (exp_valid) begin
            assert (pred_counter === exp_ctr)
                else report_mismatch("pred_counter", 32'(exp_ctr), 32'(pred_counter));
            assert (pred_hit === exp_hit)
                else report_mismatch("pred_hit", 32'(exp_hit), 32'(pred_hit));
            assert (pred_taken === exp_taken)
                else report_mismatch("pred_taken", 32'(exp_taken), 32'(pred_taken));
            assert (pred_history === exp_hist)
                else report_mismatch("pred_history", 32'(exp_hist), 32'(pred_history));
        end
        assert (miss_count === model_miss)
            else report_mismatch("miss_count", model_miss, miss_count);
    endtask

    // Check the previous cycle's result and drive the next one
    task automatic step(input logic lv, input pc_t lpc, input logic uv,
                        input pc_t upc, input logic ut, input ghr_t uh);
        @(posedge clock);
        #1;
        check_outputs();
        lookup_valid   = lv;
        lookup_pc      = lpc;
        update_valid   = uv;
        update_pc      = upc;
        update_taken   = ut;
        update_history = uh;
        apply_model(lv, lpc, uv, upc, ut, uh);
    endtask

    assert property (@(negedge clock) disable iff (!reset_n) pred_valid |-> $past(lookup_valid))
        else begin
            other_errors++;
            $display("pred_valid went high without a lookup in the cycle before at %0t", $time);
        end

    ////////////////////////////////////////
    // Stimulus

    initial begin
        ghr_t hist;
        ghr_t uh;
        pc_t  lpc;
        pc_t  upc;
        reset_n        = 1'b0;
        lookup_valid   = 1'b0;
        lookup_pc      = '0;
        update_valid   = 1'b0;
        update_pc      = '0;
        update_taken   = 1'b0;
        update_history = '0;
        mismatch_count = 0;
        other_errors   = 0;
        model_ghr      = '0;
        model_miss     = '0;
        exp_valid      = 1'b0;
        rng            = 32'h16e856e5;
        for (int b = 0; b < `BP_BANKS; b++) begin
            for (int s = 0; s < SETS; s++) begin
                model_valid[b][s] = 1'b0;
                for (int c = 0; c < `BP_CTRS; c++) begin
                    model_ctr[b][s][c] = '0;
                end
            end
        end
        repeat (4) @(posedge clock);
        #1;
        reset_n = 1'b1;

        // Cold lookups to every bank back to back
        for (int b = 0; b < 2 * `BP_BANKS; b++) begin
            step(1'b1, 32'h0000_0100 + pc_t'((b % `BP_BANKS) * 4), 1'b0, '0, 1'b0, '0);
        end

        // Saturate up then down with a lookup behind each update
        for (int i = 0; i < 10; i++) begin
            hist = model_ghr;
            step(1'b0, '0, 1'b1, PC_A, i < 5, hist);
            step(1'b1, retarget_pc(PC_A, hist), 1'b0, '0, 1'b0, '0);
        end

        // Same-cycle update and lookup on one set, then its neighbour counter
        hist = model_ghr;
        step(1'b1, PC_B, 1'b1, PC_B, 1'b1, hist);
        step(1'b1, retarget_pc(PC_B, hist), 1'b1, PC_B ^ 32'h10, 1'b1, hist);
        step(1'b1, retarget_pc(PC_B ^ 32'h10, hist), 1'b0, '0, 1'b0, '0);
        step(1'b1, retarget_pc(PC_B, hist), 1'b0, '0, 1'b0, '0);

        // History moves the same PC across sets
        for (int i = 0; i < 6; i++) begin
            step(1'b1, PC_C, 1'b1, PC_C, (i % 3) != 1, model_ghr);
            step(1'b1, PC_C, 1'b0, '0, 1'b0, '0);
        end

        ////////////////////////////////////////
        // Random traffic over a small PC pool

        for (int i = 0; i < POOL_N; i++) begin
            rng = xorshift32(rng);
            pool[i] = rng & 32'h0000_03fc;
        end
        for (int n = 0; n < RAND_CYCLES; n++) begin
            rng = xorshift32(rng);
            upc = pool[int'(rng[7:4]) % POOL_N];
            lpc = rng[14] ? upc : pool[int'(rng[19:16]) % POOL_N];
            uh  = rng[15] ? model_ghr : ghr_t'(rng[29:24]);
            step(rng[0] | rng[1], lpc, rng[2], upc, rng[3], uh);
        end
        step(1'b0, '0, 1'b0, '0, 1'b0, '0);             // Drain the last lookup
        step(1'b0, '0, 1'b0, '0, 1'b0, '0);

        $display("Done: %0d mismatches, %0d other errors", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== bp.f ====
+incdir+src
src/bp_pkg.sv
src/bp_index_hash.sv
src/bht_bank.sv
src/bp_predict_select.sv
src/bp_top.sv
dv/bp_tb.sv

// ==== Makefile ====
# Verilator build and run for the branch predictor testbench

VERILATOR  ?= verilator
TOP        ?= bp_tb
FILELIST   ?= bp.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= NO ERRORS
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
